// File: compile.f
src/ram512_pkg.sv
src/bank_config_regs.sv
src/block_mapper.sv
src/sram_strobe_gen.sv
src/cpld_ram512k.sv
tests/tb_ram512k.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_ram512k \
  -Mdir obj_dir \
  -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_ram512k)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The run counts as passed only if the testbench printed the pass line
if printf '%s\n' "$output" | grep -q '^TEST PASS$'; then
  exit 0
fi

echo "Pass line not found in simulation output"
exit 1

// File: tests/tb_ram512k.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ram512k;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DELAY = 5;

  // Kinds of memory cycle that the access task can run
  localparam int ACC_READ = 0;
  localparam int ACC_WRITE = 1;
  localparam int ACC_RFSH = 2;

  localparam int RANDOM_ACCESSES = 24;
  // Upper bound on I/O writes plus memory accesses over all phases
  localparam int NUM_OPS = 190;
  // No operation takes more than 6 cycles, the margin covers reset
  localparam int WATCHDOG_CYCLES = NUM_OPS * 6 + 50;

  // Starts low so the first clock event is the rising edge at half a period
  logic       clk = 1'b0;
  logic       reset_b;
  logic       rfsh_b;
  logic       adr15;
  logic       adr14;
  logic       adr8;
  logic       iorq_b;
  logic       mreq_b;
  logic       rd_b;
  logic       wr_b;
  logic [7:0] data;
  logic       ramcs_b;
  logic       ramoe_b;
  logic       ramwe_b;
  logic       ramdis;
  logic [4:0] ramadrhi;

  // Marks the cycle of a memory access where the outputs are compared
  logic check_en;

  int errors;
  int n_ops;
  int seed;
  logic [31:0] rnd;

  // Model of the configuration registers
  logic [2:0] m_bank;
  logic [2:0] m_scheme;
  logic       m_cardsel;
  logic       m_urom;
  logic       m_lrom;

  // Expected DUT outputs worked out from the model and the live bus
  logic [1:0] exp_quad;
  logic       exp_mapped;
  logic [1:0] exp_blk;
  logic       exp_mem;
  logic       exp_gate;
  logic       exp_ramcs_b;
  logic       exp_ramoe_b;
  logic       exp_ramdis;
  logic [4:0] exp_ramadrhi;

  cpld_ram512k UUT (
    .clk      (clk),
    .reset_b  (reset_b),
    .rfsh_b   (rfsh_b),
    .adr15    (adr15),
    .adr14    (adr14),
    .adr8     (adr8),
    .iorq_b   (iorq_b),
    .mreq_b   (mreq_b),
    .rd_b     (rd_b),
    .wr_b     (wr_b),
    .data     (data),
    .ramcs_b  (ramcs_b),
    .ramoe_b  (ramoe_b),
    .ramwe_b  (ramwe_b),
    .ramdis   (ramdis),
    .ramadrhi (ramadrhi)
  );

  initial begin
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Scheme table: the address is held before each access, so the
  // held adr15 of scheme 3 is the live one
  always_comb begin
    exp_quad = {adr15, adr14};
    exp_mapped = 1'b0;
    exp_blk = 2'd0;
    case (m_scheme)
      3'd0: begin
        exp_mapped = 1'b0;
      end
      3'd1, 3'd3: begin
        if (exp_quad == 2'd3) begin
          exp_mapped = 1'b1;
          exp_blk = 2'd3;
        end
      end
      3'd2: begin
        exp_mapped = 1'b1;
        exp_blk = exp_quad;
      end
      default: begin
        // For schemes 4 to 7 the low two bits are the scheme minus 4
        if (exp_quad == 2'd1) begin
          exp_mapped = 1'b1;
          exp_blk = m_scheme[1:0];
        end
      end
    endcase
    exp_mem = !mreq_b && rfsh_b;
    exp_ramdis = exp_mapped && m_cardsel;
    exp_ramcs_b = !(exp_ramdis && exp_mem);
    exp_ramadrhi = exp_mapped ? {m_bank, exp_blk} : 5'd0;
    // RAM reads cover 4000 to BFFF, plus any ROM area that is switched off
    exp_gate = exp_mem && ((exp_quad == 2'd1) || (exp_quad == 2'd2) ||
      ((exp_quad == 2'd3) && m_urom) || ((exp_quad == 2'd0) && m_lrom));
    exp_ramoe_b = !(exp_gate && !rd_b);
  end

  task automatic report_mismatch(input string name, input logic [7:0] expv,
                                 input logic [7:0] actv);
    errors++;
    $display("Error: %s expected 0x%h actual 0x%h at %0t", name, expv, actv, $time);
  endtask

  // Outputs are compared at the falling edge, mid-way through the access
  assert property (@(negedge clk) check_en |-> (ramcs_b == exp_ramcs_b))
    else report_mismatch("ramcs_b", 8'(exp_ramcs_b), 8'(ramcs_b));

  assert property (@(negedge clk) check_en |-> (ramoe_b == exp_ramoe_b))
    else report_mismatch("ramoe_b", 8'(exp_ramoe_b), 8'(ramoe_b));

  assert property (@(negedge clk) check_en |-> (ramdis == exp_ramdis))
    else report_mismatch("ramdis", 8'(exp_ramdis), 8'(ramdis));

  assert property (@(negedge clk) check_en |-> (ramadrhi == exp_ramadrhi))
    else report_mismatch("ramadrhi", 8'(exp_ramadrhi), 8'(ramadrhi));

  // The write strobe passes straight through on every cycle
  assert property (@(negedge clk) ramwe_b == wr_b)
    else report_mismatch("ramwe_b", 8'(wr_b), 8'(ramwe_b));

  // Refresh cycles must leave the SRAM alone
  assert property (@(negedge clk) !rfsh_b |-> ramcs_b)
    else report_mismatch("ramcs_b", 8'h01, 8'(ramcs_b));

  assert property (@(negedge clk) !rfsh_b |-> ramoe_b)
    else report_mismatch("ramoe_b", 8'h01, 8'(ramoe_b));

  // I/O write to the 7Fxx port; the model follows at the write edge
  task automatic io_write(input logic [7:0] d, input logic a8);
    @(posedge clk);
    #(DRIVE_DELAY);
    adr15 = 1'b0;
    adr8 = a8;
    data = d;
    iorq_b = 1'b0;
    wr_b = 1'b0;
    @(posedge clk);
    if (d[7:6] == 2'b11) begin
      m_bank = d[5:3];
      m_scheme = d[2:0];
      m_cardsel = a8;
    end else if (d[7:6] == 2'b10) begin
      m_urom = d[3];
      m_lrom = d[2];
    end
    #(DRIVE_DELAY);
    iorq_b = 1'b1;
    wr_b = 1'b1;
    adr8 = 1'b0;
    data = 8'h00;
    n_ops++;
  endtask

  task automatic set_scheme(input logic [2:0] bank, input logic [2:0] scheme,
                            input logic a8);
    io_write({2'b11, bank, scheme}, a8);
  endtask

  task automatic set_rom(input logic urom, input logic lrom);
    io_write({4'b1000, urom, lrom, 2'b00}, 1'b0);
  endtask

  task automatic mem_access(input logic [1:0] quad, input int kind);
    @(posedge clk);
    #(DRIVE_DELAY);
    // The address settles with mreq_b high so the mapper latches adr15
    adr15 = quad[1];
    adr14 = quad[0];
    mreq_b = 1'b1;
    rd_b = 1'b1;
    wr_b = 1'b1;
    rfsh_b = 1'b1;
    repeat (2) @(posedge clk);
    #(DRIVE_DELAY);
    mreq_b = 1'b0;
    rd_b = (kind == ACC_READ) ? 1'b0 : 1'b1;
    wr_b = (kind == ACC_WRITE) ? 1'b0 : 1'b1;
    rfsh_b = (kind == ACC_RFSH) ? 1'b0 : 1'b1;
    check_en = 1'b1;
    @(posedge clk);
    #(DRIVE_DELAY);
    mreq_b = 1'b1;
    rd_b = 1'b1;
    wr_b = 1'b1;
    rfsh_b = 1'b1;
    check_en = 1'b0;
    n_ops++;
  endtask

  task automatic sweep_quadrants(input int kind);
    for (int q = 0; q < 4; q++) begin
      mem_access(q[1:0], kind);
    end
  endtask

  // The synchronized reset has to be free two edges after reset_b rises
  task automatic check_reset_release();
    repeat (2) @(posedge clk);
    #1;
    if (UUT.sys_reset_b !== 1'b1) begin
      errors++;
      $display("Internal reset was still active two clock edges after release");
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    reset_b = 1'b0;
    rfsh_b = 1'b1;
    adr15 = 1'b0;
    adr14 = 1'b0;
    adr8 = 1'b0;
    iorq_b = 1'b1;
    mreq_b = 1'b1;
    rd_b = 1'b1;
    wr_b = 1'b1;
    data = 8'h00;
    check_en = 1'b0;
    errors = 0;
    n_ops = 0;
    seed = 97414;
    rnd = '0;
    m_bank = 3'd0;
    m_scheme = 3'd0;
    m_cardsel = 1'b0;
    m_urom = 1'b0;
    m_lrom = 1'b0;

    repeat (2) @(posedge clk);
    #(DRIVE_DELAY);
    reset_b = 1'b1;
    check_reset_release();

    // Out of reset the card claims nothing and the ROMs are enabled
    for (int q = 0; q < 4; q++) begin
      mem_access(q[1:0], ACC_READ);
      mem_access(q[1:0], ACC_WRITE);
    end

    // Flat scheme maps every quadrant into a random bank
    repeat (4) begin
      rnd = $random(seed);
      set_scheme(rnd[2:0], 3'd2, 1'b1);
      sweep_quadrants(ACC_READ);
    end

    // Every scheme with the card selected
    for (int s = 0; s < 8; s++) begin
      rnd = $random(seed);
      set_scheme(rnd[2:0], s[2:0], 1'b1);
      sweep_quadrants(ACC_READ);
    end

    // adr8 low deselects the card, whatever the scheme
    for (int s = 0; s < 8; s++) begin
      rnd = $random(seed);
      set_scheme(rnd[2:0], s[2:0], 1'b0);
      sweep_quadrants(ACC_WRITE);
    end

    // ROM disable bits open the SRAM for reads in C000 and 0000
    set_rom(1'b1, 1'b0);
    sweep_quadrants(ACC_READ);
    set_rom(1'b0, 1'b1);
    sweep_quadrants(ACC_READ);
    set_rom(1'b1, 1'b1);
    sweep_quadrants(ACC_READ);
    set_rom(1'b0, 1'b0);
    sweep_quadrants(ACC_READ);

    // Refresh with everything mapped and both ROMs off still stays quiet
    rnd = $random(seed);
    set_scheme(rnd[2:0], 3'd2, 1'b1);
    set_rom(1'b1, 1'b1);
    sweep_quadrants(ACC_RFSH);
    set_rom(1'b0, 1'b0);

    // Random mix of settings and cycles
    repeat (RANDOM_ACCESSES) begin
      rnd = $random(seed);
      if (rnd[7:5] == 3'd0) begin
        set_scheme(rnd[10:8], rnd[13:11], rnd[14]);
      end
      mem_access(rnd[1:0], int'(rnd[3:2]) % 3);
    end

    #(CLK_PERIOD);
    $display("Finished %0d operations with %0d errors", n_ops, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/cpld_ram512k.sv
`timescale 1ns/1ps
`default_nettype none

module cpld_ram512k (
  input  logic       clk,
  input  logic       reset_b,
  input  logic       rfsh_b,
  input  logic       adr15,
  input  logic       adr14,
  input  logic       adr8,
  input  logic       iorq_b,
  input  logic       mreq_b,
  input  logic       rd_b,
  input  logic       wr_b,
  input  logic [7:0] data,
  output logic       ramcs_b,
  output logic       ramoe_b,
  output logic       ramwe_b,
  output logic       ramdis,
  output logic [4:0] ramadrhi
);

  // Two-stage synchronizer, bit 1 is the released reset
  logic [1:0] reset_sync_q;
  logic       sys_reset_b;

  ram512_pkg::cpu_bus_t   bus;
  ram512_pkg::bank_cfg_t  cfg;
  ram512_pkg::map_sel_t   map;
  ram512_pkg::sram_ctrl_t ctrl;

  // Reset asserts at once and releases on the second clock edge
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      reset_sync_q <= '0;
    end else begin
      reset_sync_q <= {reset_sync_q[0], 1'b1};
    end
  end

  assign sys_reset_b = reset_sync_q[1];

  // Gather the Z80 pins into one bus value for the blocks below
  assign bus = '{
    adr15:  adr15,
    adr14:  adr14,
    adr8:   adr8,
    iorq_b: iorq_b,
    mreq_b: mreq_b,
    rd_b:   rd_b,
    wr_b:   wr_b,
    rfsh_b: rfsh_b,
    data:   data
  };

  bank_config_regs u_bank_config_regs (
    .clk     (clk),
    .reset_b (sys_reset_b),
    .bus     (bus),
    .cfg     (cfg)
  );

  block_mapper u_block_mapper (
    .clk     (clk),
    .reset_b (sys_reset_b),
    .bus     (bus),
    .cfg     (cfg),
    .map     (map)
  );

  sram_strobe_gen u_sram_strobe_gen (
    .bus  (bus),
    .cfg  (cfg),
    .map  (map),
    .ctrl (ctrl)
  );

  assign ramcs_b  = ctrl.ramcs_b;
  assign ramoe_b  = ctrl.ramoe_b;
  assign ramwe_b  = ctrl.ramwe_b;
  // Plain output here, low whenever the card leaves the access alone
  assign ramdis   = ctrl.ramdis;
  assign ramadrhi = map.ramadrhi;

endmodule

`default_nettype wire

// File: src/sram_strobe_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sram_strobe_gen (
  input  ram512_pkg::cpu_bus_t   bus,
  input  ram512_pkg::bank_cfg_t  cfg,
  input  ram512_pkg::map_sel_t   map,
  output ram512_pkg::sram_ctrl_t ctrl
);

  // A real memory cycle, refresh excluded
  logic mem_req;

  // Quadrant of the live address
  ram512_pkg::quad_t quad;

  // True when the CPU reads RAM rather than ROM, worked out locally
  // instead of waiting for the gate array
  logic int_ramrd;

  // Card owns this access
  logic card_hit;

  assign mem_req = !bus.mreq_b && bus.rfsh_b;
  assign quad    = {bus.adr15, bus.adr14};

  always_comb begin
    int_ramrd = 1'b0;
    if (mem_req) begin
      if (bus.adr15 != bus.adr14) begin
        // 4000 to BFFF never overlaps a ROM
        int_ramrd = 1'b1;
      end else if (cfg.urom_disable && (quad == ram512_pkg::QUAD_HIGH)) begin
        int_ramrd = 1'b1;
      end else if (cfg.lrom_disable && (quad == ram512_pkg::QUAD_LOW)) begin
        int_ramrd = 1'b1;
      end
    end
  end

  assign card_hit = map.exp_ram && cfg.cardsel;

  // OE only opens on RAM reads, so a ROM read never fights the SRAM
  assign ctrl.ramoe_b = !(int_ramrd && !bus.rd_b);
  // Write enable is qualified by CS at the SRAM
  assign ctrl.ramwe_b = bus.wr_b;
  assign ctrl.ramcs_b = !(card_hit && mem_req);
  // Internal RAM is held off whenever the card maps the address
  assign ctrl.ramdis  = card_hit;

  // The SRAM must never be selected outside a memory request
  always_comb begin
    assert final (ctrl.ramcs_b || !bus.mreq_b)
      else $error("ramcs_b low without mreq_b");
  end

endmodule

`default_nettype wire

// File: src/block_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module block_mapper (
  input  logic                  clk,
  input  logic                  reset_b,
  input  ram512_pkg::cpu_bus_t  bus,
  input  ram512_pkg::bank_cfg_t cfg,
  output ram512_pkg::map_sel_t  map
);

  // mreq_b one cycle late, so the latch can tell when a request has begun
  logic mreq_b_q;

  // adr15 as it stood before the current memory request
  logic adr15_q;

  // Quadrant of the live address, and the one seen through the held adr15
  ram512_pkg::quad_t quad;
  ram512_pkg::quad_t held_quad;

  // Lookup result before it is packed onto the output
  logic                                hit;
  logic [ram512_pkg::BLOCK_W-1:0]      blk;
  logic [ram512_pkg::SCHEME_W-1:0]     window_off;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      mreq_b_q <= 1'b1;
      adr15_q  <= 1'b0;
    end else begin
      mreq_b_q <= bus.mreq_b;
      // Freeze adr15 once a request is under way; scheme 3 keys off the
      // address the CPU put out before the gate array can move it
      if (mreq_b_q) begin
        adr15_q <= bus.adr15;
      end
    end
  end

  assign quad      = {bus.adr15, bus.adr14};
  assign held_quad = {adr15_q, bus.adr14};

  // Offset of a window scheme from scheme 4 gives its block
  assign window_off = cfg.scheme - ram512_pkg::SCHEME_WINDOW_MIN;

  // DK'Tronics scheme table, see the scheme codes in the package
  always_comb begin
    hit = 1'b0;
    blk = '0;
    case (cfg.scheme)
      ram512_pkg::SCHEME_INTERNAL: begin
        // Everything stays in the internal 64K
        hit = 1'b0;
      end
      ram512_pkg::SCHEME_HIGH_ONLY: begin
        if (quad == ram512_pkg::QUAD_HIGH) begin
          hit = 1'b1;
          blk = ram512_pkg::BLOCK_TOP;
        end
      end
      ram512_pkg::SCHEME_FLAT: begin
        // The whole 64K comes from the expansion bank
        hit = 1'b1;
        blk = quad;
      end
      ram512_pkg::SCHEME_C3: begin
        // Only the held address decides; a live adr15 could already be
        // remapped by the host for the 4000 alias of C000
        if (held_quad == ram512_pkg::QUAD_HIGH) begin
          hit = 1'b1;
          blk = ram512_pkg::BLOCK_TOP;
        end
      end
      default: begin
        // Schemes 4 to 7 swap one block into the 4000 window
        if (quad == ram512_pkg::QUAD_WINDOW) begin
          hit = 1'b1;
          blk = window_off[ram512_pkg::BLOCK_W-1:0];
        end
      end
    endcase
  end

  assign map.exp_ram  = hit;
  // Keep the upper address quiet when the internal RAM is in use
  assign map.ramadrhi = hit ? {cfg.bank, blk} : '0;

  // A mapped access must present a clean SRAM address at every edge
  assert property (@(posedge clk) disable iff (!reset_b)
    map.exp_ram |-> !$isunknown(map.ramadrhi))
    else $error("ramadrhi unknown during an expansion access");

endmodule

`default_nettype wire

// File: src/bank_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bank_config_regs (
  input  logic                  clk,
  input  logic                  reset_b,
  input  ram512_pkg::cpu_bus_t  bus,
  output ram512_pkg::bank_cfg_t cfg
);

  // Any I/O write with adr15 low hits the 7Fxx port range
  logic io_wr;

  // Register selects, decoded from the tag in data bits 7:6
  logic ram_ctrl_sel;
  logic rom_ctrl_sel;

  assign io_wr = !bus.iorq_b && !bus.wr_b && !bus.adr15;

  // 0b11cccbbb picks a bank and a scheme
  assign ram_ctrl_sel = io_wr && (bus.data[7:6] == ram512_pkg::RAM_CTRL_TAG);

  // 0b10xxUL00 sets the upper and lower ROM disable bits
  assign rom_ctrl_sel = io_wr && (bus.data[7:6] == ram512_pkg::ROM_CTRL_TAG);

  // Registers load on the rising edge that sees the write strobes low
  // and take effect on the outputs one cycle later
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      // All zero means scheme 0, card not selected and both ROMs enabled
      cfg <= '0;
    end else if (ram_ctrl_sel) begin
      cfg.bank   <= bus.data[5:3];
      cfg.scheme <= bus.data[2:0];
      // The port address bit 8 tells this card from a second one
      cfg.cardsel <= bus.adr8;
    end else if (rom_ctrl_sel) begin
      cfg.urom_disable <= bus.data[3];
      cfg.lrom_disable <= bus.data[2];
    end
  end

  // The two register writes share one strobe decode, so a broken tag
  // compare would load both registers from one write
  assert property (@(posedge clk) disable iff (!reset_b)
    !(ram_ctrl_sel && rom_ctrl_sel))
    else $error("RAM-control and ROM-control selects both active");

endmodule

`default_nettype wire

// File: src/ram512_pkg.sv
`default_nettype none

package ram512_pkg;

  // Width of the 64K bank select written to the RAM-control port
  localparam int BANK_W = 3;

  // Width of the block switching scheme code
  localparam int SCHEME_W = 3;

  // Upper SRAM address is bank followed by the 16K block number
  localparam int RAMADRHI_W = 5;

  // Block number inside a 64K bank
  localparam int BLOCK_W = RAMADRHI_W - BANK_W;

  // The 16K quadrant of a Z80 address, given by {adr15, adr14}
  typedef logic [1:0] quad_t;

  // Data bits 7:6 of an I/O write pick which register is loaded
  localparam logic [1:0] RAM_CTRL_TAG = 2'b11;
  localparam logic [1:0] ROM_CTRL_TAG = 2'b10;

  // DK'Tronics block schemes, held in data bits 2:0 of a RAM-control write
  localparam logic [SCHEME_W-1:0] SCHEME_INTERNAL   = 3'd0;
  localparam logic [SCHEME_W-1:0] SCHEME_HIGH_ONLY  = 3'd1;
  localparam logic [SCHEME_W-1:0] SCHEME_FLAT       = 3'd2;
  localparam logic [SCHEME_W-1:0] SCHEME_C3         = 3'd3;
  // Schemes 4 to 7 all map the 4000 window, each to its own block
  localparam logic [SCHEME_W-1:0] SCHEME_WINDOW_MIN = 3'd4;

  // Quadrants 0000, 4000 and C000; 8000 has no special meaning here
  localparam quad_t QUAD_LOW    = 2'b00;
  localparam quad_t QUAD_WINDOW = 2'b01;
  localparam quad_t QUAD_HIGH   = 2'b11;

  // Schemes 1 and 3 always land on the top block of the bank
  localparam logic [BLOCK_W-1:0] BLOCK_TOP = 2'b11;

  // Z80 bus as seen by the card, all strobes active low
  typedef struct packed {
    logic       adr15;
    logic       adr14;
    logic       adr8;
    logic       iorq_b;
    logic       mreq_b;
    logic       rd_b;
    logic       wr_b;
    logic       rfsh_b;
    logic [7:0] data;
  } cpu_bus_t;

  // Configuration registers loaded by the two I/O writes
  typedef struct packed {
    logic [BANK_W-1:0]   bank;
    logic [SCHEME_W-1:0] scheme;
    // Card claims accesses only when the port write had adr8 set
    logic                cardsel;
    logic                urom_disable;
    logic                lrom_disable;
  } bank_cfg_t;

  // Result of the scheme lookup for the current access
  typedef struct packed {
    logic                  exp_ram;
    logic [RAMADRHI_W-1:0] ramadrhi;
  } map_sel_t;

  // SRAM strobes and the internal RAM disable line
  typedef struct packed {
    logic ramcs_b;
    logic ramoe_b;
    logic ramwe_b;
    logic ramdis;
  } sram_ctrl_t;

endpackage

`default_nettype wire
